// File: logic/rx_fifo.sv
module rx_fifo (
   input  logic       clk,
   input  logic       reset,
   input  logic       push,
   input  logic       pop,
   input  logic [7:0] din,
   output logic [7:0] head,
   output logic       empty,
   output logic       full
);

   logic [7:0] mem [uart_pkg::fifo_depth];

   logic [uart_pkg::fifo_addr_width-1:0] wr_ptr;
   logic [uart_pkg::fifo_addr_width-1:0] rd_ptr;
   logic [uart_pkg::fifo_addr_width:0]   count;  // One extra bit to hold depth

   logic do_push;
   logic do_pop;

   assign do_push = push & ~full;   // Dropped when full
   assign do_pop  = pop & ~empty;

   assign empty = (count == '0);
   assign full  = (count == uart_pkg::fifo_depth);
   assign head  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;

         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: logic/uart.sv
module uart (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             cs,
   input  logic                             wen,
   input  logic [3:0]                       addr,
   input  logic [uart_pkg::data_width-1:0]  din,
   output logic [uart_pkg::data_width-1:0]  dout,
   input  logic                             rxd,
   output logic                             txd
);

   uart_pkg::reg_addr_e reg_sel;

   logic wr;
   logic scratch_sel;

   logic [uart_pkg::data_width-1:0] control;
   logic [uart_pkg::data_width-1:0] cycles_per_bit;
   logic [uart_pkg::data_width-1:0] scratch [4];
   logic                            break_flag;

   logic tx_start;
   logic tx_busy;

   logic       rx_en;
   logic       rx_valid;
   logic       rx_brk;
   logic [7:0] rx_data;

   logic       fifo_pop;
   logic [7:0] fifo_head;
   logic       fifo_empty;
   logic       fifo_full;

   logic [uart_pkg::data_width-1:0] rstat_value;
   logic [uart_pkg::data_width-1:0] tstat_value;
   logic [uart_pkg::data_width-1:0] head_word;

   // Bus decode
   assign reg_sel     = uart_pkg::reg_addr_e'(addr);
   assign wr          = cs & wen;
   assign scratch_sel = (addr[3:2] == uart_pkg::scratch_page);

   // Writes to the data register while busy are lost
   assign tx_start = wr && (reg_sel == uart_pkg::reg_dr)
                     && control[uart_pkg::ctrl_tx_en] && !tx_busy;
   assign fifo_pop = wr && (reg_sel == uart_pkg::reg_pop);
   assign rx_en    = control[uart_pkg::ctrl_rx_en];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control        <= '0;
         cycles_per_bit <= uart_pkg::reset_cycles_per_bit;
      end
      else if (wr)
      begin
         if (reg_sel == uart_pkg::reg_ctrl)
            control <= din;
         if (reg_sel == uart_pkg::reg_cpb)
            cycles_per_bit <= din;
      end
   end

   // Break stays set until reset or a control write
   always_ff @(posedge clk)
   begin
      if (reset)
         break_flag <= 1'b0;
      else if (rx_brk)
         break_flag <= 1'b1; // New break wins over a clear
      else if (wr && reg_sel == uart_pkg::reg_ctrl)
         break_flag <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end
      else if (wr && scratch_sel)
         scratch[addr[1:0]] <= din;
   end

   uart_tx tx_i (
      .clk            (clk),
      .reset          (reset),
      .start          (tx_start),
      .data           (din[7:0]),
      .cycles_per_bit (cycles_per_bit),
      .txd            (txd),
      .busy           (tx_busy)
   );

   uart_rx rx_i (
      .clk            (clk),
      .reset          (reset),
      .enable         (rx_en),
      .rxd            (rxd),
      .cycles_per_bit (cycles_per_bit),
      .valid          (rx_valid),
      .brk            (rx_brk),
      .data           (rx_data)
   );

   // Good bytes go straight into the queue
   rx_fifo fifo_i (
      .clk   (clk),
      .reset (reset),
      .push  (rx_valid),
      .pop   (fifo_pop),
      .din   (rx_data),
      .head  (fifo_head),
      .empty (fifo_empty),
      .full  (fifo_full)
   );

   assign head_word = {{(uart_pkg::data_width-8){1'b0}}, fifo_head};

   always_comb
   begin
      rstat_value = '0;
      rstat_value[uart_pkg::rstat_not_empty] = ~fifo_empty;
      rstat_value[uart_pkg::rstat_break]     = break_flag;
      rstat_value[uart_pkg::rstat_empty]     = fifo_empty;
      rstat_value[uart_pkg::rstat_full]      = fifo_full;
      rstat_value[uart_pkg::rstat_head_lsb +: 8] = fifo_head;
   end

   always_comb
   begin
      tstat_value = '0;
      tstat_value[uart_pkg::tstat_idle] = ~tx_busy;
   end

   // Read mux, no side effects
   always_comb
   begin
      case (reg_sel)
         uart_pkg::reg_dr:    dout = head_word;
         uart_pkg::reg_ctrl:  dout = control;
         uart_pkg::reg_rstat: dout = rstat_value;
         uart_pkg::reg_tstat: dout = tstat_value;
         uart_pkg::reg_cpb:   dout = cycles_per_bit;
         uart_pkg::reg_queue: dout = head_word;
         default:
         begin
            if (scratch_sel)
               dout = scratch[addr[1:0]];
            else
               dout = '0; // Pop and unused addresses
         end
      endcase
   end

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

   // Bus and register widths
   localparam int data_width = 32;

   // Receive FIFO geometry
   localparam int fifo_addr_width = 7;
   localparam int fifo_depth = 1 << fifo_addr_width; // 128 bytes

   // 25 MHz clock at 115200 baud
   localparam logic [data_width-1:0] reset_cycles_per_bit = 32'd217;

   // Register map on the 4-bit address bus
   typedef enum logic [3:0] {
      reg_dr    = 4'd0,  // Tx on write, FIFO head on read
      reg_ctrl  = 4'd1,
      reg_rstat = 4'd2,
      reg_tstat = 4'd3,
      reg_cpb   = 4'd4,
      reg_queue = 4'd5,  // FIFO head, read only
      reg_pop   = 4'd6   // Write pops the FIFO
   } reg_addr_e;

   // Scratch registers occupy addresses 12 to 15
   localparam logic [1:0] scratch_page = 2'b11;

   // Control register bits
   localparam int ctrl_rx_en = 0;
   localparam int ctrl_tx_en = 1;

   // Receive status bits
   localparam int rstat_not_empty = 0;
   localparam int rstat_break     = 1; // Sticky
   localparam int rstat_empty     = 4;
   localparam int rstat_full      = 5;
   localparam int rstat_head_lsb  = 8; // Head byte in bits 15..8

   // Transmit status bits
   localparam int tstat_idle = 0;

   // Transmitter states
   typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

   // Receiver states
   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

// File: logic/uart_rx.sv
module uart_rx (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             enable,
   input  logic                             rxd,
   input  logic [uart_pkg::data_width-1:0]  cycles_per_bit,
   output logic                             valid,
   output logic                             brk,
   output logic [7:0]                       data
);

   uart_pkg::rx_state_e state;

   logic rxd_meta;
   logic rxd_sync;
   logic rxd_prev;
   logic fall;

   logic [uart_pkg::data_width-1:0] bit_count;
   logic [uart_pkg::data_width-1:0] half_cpb;
   logic [2:0]                      bit_idx;
   logic                            mid_start;
   logic                            mid_bit;

   // Two flop synchroniser plus one more for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign fall = rxd_prev & ~rxd_sync;

   assign half_cpb  = cycles_per_bit >> 1;
   assign mid_start = (bit_count == half_cpb);
   assign mid_bit   = (bit_count == cycles_per_bit - 1'b1); // One full bit later

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= uart_pkg::rx_idle;
         bit_count <= '0;
         bit_idx   <= '0;
         valid     <= 1'b0;
         brk       <= 1'b0;
      end
      else
      begin
         valid     <= 1'b0;
         brk       <= 1'b0;
         bit_count <= bit_count + 1'b1;

         if (!enable)
            state <= uart_pkg::rx_idle;
         else
            case (state)
               uart_pkg::rx_idle:
               begin
                  bit_count <= '0;
                  if (fall)
                     state <= uart_pkg::rx_start;
               end
               uart_pkg::rx_start:
               begin
                  if (mid_start)
                  begin
                     bit_count <= '0;
                     bit_idx   <= '0;
                     // Line back high mid start bit means a glitch
                     state <= rxd_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
                  end
               end
               uart_pkg::rx_data:
               begin
                  if (mid_bit)
                  begin
                     bit_count <= '0;
                     bit_idx   <= bit_idx + 1'b1;
                     if (bit_idx == 3'd7)
                        state <= uart_pkg::rx_stop;
                  end
               end
               uart_pkg::rx_stop:
               begin
                  if (mid_bit)
                  begin
                     state <= uart_pkg::rx_idle;
                     valid <= rxd_sync;
                     brk   <= ~rxd_sync;  // Stop bit low
                  end
               end
               default: state <= uart_pkg::rx_idle;
            endcase
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk)
   begin
      if (enable && state == uart_pkg::rx_data && mid_bit)
         data <= {rxd_sync, data[7:1]};
   end

endmodule

// File: logic/uart_tx.sv
module uart_tx (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             start,
   input  logic [7:0]                       data,
   input  logic [uart_pkg::data_width-1:0]  cycles_per_bit,
   output logic                             txd,
   output logic                             busy
);

   uart_pkg::tx_state_e state;

   logic [uart_pkg::data_width-1:0] bit_count; // Cycles into current bit
   logic [2:0]                      bit_idx;
   logic [7:0]                      shift;
   logic                            bit_done;

   assign bit_done = (bit_count == cycles_per_bit - 1'b1);
   assign busy = (state != uart_pkg::tx_idle);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= uart_pkg::tx_idle;
         bit_count <= '0;
         bit_idx   <= '0;
         txd       <= 1'b1; // Line idles high
      end
      else
      begin
         // Bit period counter runs whenever a frame is in flight
         if (state == uart_pkg::tx_idle || bit_done)
            bit_count <= '0;
         else
            bit_count <= bit_count + 1'b1;

         case (state)
            uart_pkg::tx_idle:
            begin
               if (start)
               begin
                  state <= uart_pkg::tx_start;
                  txd   <= 1'b0; // Start bit
               end
            end
            uart_pkg::tx_start:
            begin
               if (bit_done)
               begin
                  state   <= uart_pkg::tx_data;
                  bit_idx <= '0;
                  txd     <= shift[0];
               end
            end
            uart_pkg::tx_data:
            begin
               if (bit_done)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                  begin
                     state <= uart_pkg::tx_stop;
                     txd   <= 1'b1;
                  end
                  else
                     txd <= shift[1];
               end
            end
            uart_pkg::tx_stop:
            begin
               if (bit_done)
                  state <= uart_pkg::tx_idle;
            end
            default: state <= uart_pkg::tx_idle;
         endcase
      end
   end

   // Byte latched on start, shifted right after each data bit
   always_ff @(posedge clk)
   begin
      if (state == uart_pkg::tx_idle && start)
         shift <= data;
      else if (state == uart_pkg::tx_data && bit_done)
         shift <= shift >> 1;
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module uart_tb -o uart_sim

./obj_dir/uart_sim 2>&1 | tee sim.log

if grep -q "PASS: all tests" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: sim.f
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/rx_fifo.sv
logic/uart.sv
verification/uart_properties.sv
verification/uart_tb.sv

// File: verification/uart_properties.sv
module uart_properties (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             cs,
   input  logic                             wen,
   input  logic [3:0]                       addr,
   input  logic [uart_pkg::data_width-1:0]  control,
   input  logic [uart_pkg::data_width-1:0]  cycles_per_bit,
   input  logic                             tx_busy,
   input  logic                             txd,
   input  logic                             fifo_empty,
   input  logic                             fifo_full
);

   logic [uart_pkg::data_width-1:0] busy_len; // Cycles busy in the current frame

   always_ff @(posedge clk)
   begin
      if (reset || !tx_busy)
         busy_len <= '0;
      else
         busy_len <= busy_len + 1'b1;
   end

   // Line idles high between frames
   idle_line_high: assert property (
      @(posedge clk) disable iff (reset) !tx_busy |-> txd)
      else $error("txd low while the transmitter is idle");

   // Full frame is start, 8 data and stop bits
   frame_length: assert property (
      @(posedge clk) disable iff (reset)
      $fell(tx_busy) |-> (busy_len == 10 * cycles_per_bit))
      else $error("transmitter busy ended after %0d cycles", busy_len);

   // Data write with tx enabled starts a frame on the next edge
   tx_launch: assert property (
      @(posedge clk) disable iff (reset)
      (cs && wen && addr == uart_pkg::reg_dr && control[uart_pkg::ctrl_tx_en] && !tx_busy)
      |=> (tx_busy && !txd))
      else $error("data write did not start a frame");

   fifo_flags: assert property (
      @(posedge clk) disable iff (reset) !(fifo_empty && fifo_full))
      else $error("receive FIFO flagged empty and full at once");

endmodule

// File: verification/uart_tb.sv
module uart_tb;

   logic        clk;
   logic        reset;
   logic        cs;
   logic        wen;
   logic [3:0]  addr;
   logic [31:0] din;
   logic [31:0] dout;
   logic        rxd;
   logic        txd;

   int          errors;
   int          checks;
   int          bit_cycles;  // cpb used by the serial driver and monitor
   logic [31:0] rng;
   logic [31:0] rd;
   logic [31:0] v;
   logic [7:0]  got;
   logic [7:0]  sent [130];

   uart dut_i (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wen   (wen),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .rxd   (rxd),
      .txd   (txd)
   );

   bind uart uart_properties props_i (
      .clk            (clk),
      .reset          (reset),
      .cs             (cs),
      .wen            (wen),
      .addr           (addr),
      .control        (control),
      .cycles_per_bit (cycles_per_bit),
      .tx_busy        (tx_busy),
      .txd            (txd),
      .fifo_empty     (fifo_empty),
      .fifo_full      (fifo_full)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] rand_word();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check(input string name, input logic [31:0] got_v, input logic [31:0] exp_v);
      checks++;
      assert (got_v === exp_v)
      else
      begin
         errors++;
         $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got_v, exp_v);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("Checks run: %0d, errors: %0d plus one timeout", checks, errors);
      $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
      @(negedge clk);
      cs   = 1'b1;
      wen  = 1'b1;
      addr = a;
      din  = d;
      @(negedge clk);
      cs  = 1'b0;
      wen = 1'b0;
   endtask

   task automatic bus_read(input logic [3:0] a, output logic [31:0] d);
      @(negedge clk);
      cs   = 1'b1;
      wen  = 1'b0;
      addr = a;
      @(posedge clk);
      d = dout; // Combinational read, settled since the falling edge
      @(negedge clk);
      cs = 1'b0;
   endtask

   task automatic expect_reg(input string name, input logic [3:0] a, input logic [31:0] exp_v);
      logic [31:0] r;
      bus_read(a, r);
      check(name, r, exp_v);
   endtask

   // Poll one status bit, one read per cycle
   task automatic wait_bit(input logic [3:0] a, input int b, input logic val, input string what);
      int          n;
      logic [31:0] r;
      n = 0;
      bus_read(a, r);
      while (r[b] !== val && n < 2000)
      begin
         bus_read(a, r);
         n++;
      end
      if (r[b] !== val)
         abort_on_timeout(what);
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, b, 1'b0};
      @(negedge clk);
      for (int i = 0; i < 10; i++)
      begin
         rxd = frame[i];
         repeat (bit_cycles) @(negedge clk);
      end
      rxd = 1'b1;
      if (!stop_bit)
         repeat (bit_cycles) @(negedge clk); // Idle gap so the next start edge is seen
   endtask

   // Samples txd in the middle of each bit
   task automatic capture_tx(output logic [7:0] b);
      int   n;
      logic start_bit;
      n = 0;
      while (txd !== 1'b0 && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (txd !== 1'b0)
         abort_on_timeout("start bit on txd");
      else
      begin
         repeat (bit_cycles / 2) @(negedge clk);
         start_bit = txd;
         for (int i = 0; i < 8; i++)
         begin
            repeat (bit_cycles) @(negedge clk);
            b[i] = txd;
         end
         repeat (bit_cycles) @(negedge clk);
         check("txd start bit", {31'h0, start_bit}, 32'h0);
         check("txd stop bit", {31'h0, txd}, 32'h1);
      end
   endtask

   task automatic check_line_idle(input int cycles);
      int lows;
      lows = 0;
      repeat (cycles)
      begin
         @(negedge clk);
         if (txd !== 1'b1)
            lows++;
      end
      check("txd low cycles", lows, 32'h0);
   endtask

   initial
   begin
      errors     = 0;
      checks     = 0;
      bit_cycles = 8;
      rng        = 32'd45462;
      reset      = 1'b1;
      cs         = 1'b0;
      wen        = 1'b0;
      addr       = 4'h0;
      din        = 32'h0;
      rxd        = 1'b1;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // Reset values, head byte undefined until the first push
      expect_reg("ctrl", uart_pkg::reg_ctrl, 32'h0);
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff, 32'd1 << uart_pkg::rstat_empty);
      expect_reg("tstat", uart_pkg::reg_tstat, 32'd1 << uart_pkg::tstat_idle);
      expect_reg("cpb", uart_pkg::reg_cpb, 32'd217);
      expect_reg("pop", uart_pkg::reg_pop, 32'h0);
      for (int a = 12; a < 16; a++)
         expect_reg("scratch", 4'(a), 32'h0);
      for (int a = 12; a < 16; a++)
      begin
         v = rand_word();
         bus_write(4'(a), v);
         expect_reg("scratch", 4'(a), v);
      end
      v = rand_word();
      bus_write(uart_pkg::reg_ctrl, v);
      expect_reg("ctrl", uart_pkg::reg_ctrl, v);
      v = rand_word();
      bus_write(uart_pkg::reg_cpb, v);
      expect_reg("cpb", uart_pkg::reg_cpb, v);
      bus_write(uart_pkg::reg_ctrl, 32'h0);
      bus_write(uart_pkg::reg_rstat, 32'hffff_ffff);
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff, 32'd1 << uart_pkg::rstat_empty);
      bus_write(uart_pkg::reg_cpb, bit_cycles);

      // Transmit random bytes
      bus_write(uart_pkg::reg_ctrl, 32'd1 << uart_pkg::ctrl_tx_en);
      for (int k = 0; k < 4; k++)
      begin
         v = rand_word();
         fork
            capture_tx(got);
            begin
               bus_write(uart_pkg::reg_dr, v);
               expect_reg("tstat in frame", uart_pkg::reg_tstat, 32'h0);
            end
         join
         check("txd byte", {24'h0, got}, {24'h0, v[7:0]});
         wait_bit(uart_pkg::reg_tstat, uart_pkg::tstat_idle, 1'b1, "transmitter idle");
         expect_reg("tstat", uart_pkg::reg_tstat, 32'd1 << uart_pkg::tstat_idle);
      end

      // Second write lands while busy and is dropped
      v = rand_word();
      fork
         capture_tx(got);
         begin
            bus_write(uart_pkg::reg_dr, v);
            bus_write(uart_pkg::reg_dr, ~v);
         end
      join
      check("txd byte", {24'h0, got}, {24'h0, v[7:0]});
      wait_bit(uart_pkg::reg_tstat, uart_pkg::tstat_idle, 1'b1, "transmitter idle");
      check_line_idle(10 * bit_cycles);
      bus_write(uart_pkg::reg_ctrl, 32'h0);
      bus_write(uart_pkg::reg_dr, rand_word());
      check_line_idle(10 * bit_cycles);

      // Receive path, bytes come back in order
      bus_write(uart_pkg::reg_ctrl, 32'd1 << uart_pkg::ctrl_rx_en);
      for (int k = 0; k < 4; k++)
      begin
         v = rand_word();
         sent[k] = v[7:0];
         send_frame(sent[k], 1'b1);
      end
      for (int k = 0; k < 4; k++)
      begin
         wait_bit(uart_pkg::reg_rstat, uart_pkg::rstat_not_empty, 1'b1, "received byte");
         expect_reg("dr", uart_pkg::reg_dr, {24'h0, sent[k]});
         expect_reg("queue", uart_pkg::reg_queue, {24'h0, sent[k]});
         bus_write(uart_pkg::reg_pop, 32'h0);
      end
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff, 32'd1 << uart_pkg::rstat_empty);

      // Break, then frames with the receiver off
      v = rand_word();
      send_frame(v[7:0], 1'b0);
      wait_bit(uart_pkg::reg_rstat, uart_pkg::rstat_break, 1'b1, "break flag");
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff,
            (32'd1 << uart_pkg::rstat_break) | (32'd1 << uart_pkg::rstat_empty));
      bus_write(uart_pkg::reg_ctrl, 32'h0); // Also clears break
      send_frame(8'h5a, 1'b1);
      send_frame(8'ha5, 1'b1);
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff, 32'd1 << uart_pkg::rstat_empty);

      // Overfill the FIFO by two
      bus_write(uart_pkg::reg_ctrl, 32'd1 << uart_pkg::ctrl_rx_en);
      for (int k = 0; k < 130; k++)
      begin
         v = rand_word();
         sent[k] = v[7:0];
         send_frame(sent[k], 1'b1);
         if (k == 126)
         begin
            bus_read(uart_pkg::reg_rstat, rd);
            check("rstat full", {31'h0, rd[uart_pkg::rstat_full]}, 32'h0);
         end
         if (k == 127)
            wait_bit(uart_pkg::reg_rstat, uart_pkg::rstat_full, 1'b1, "FIFO full");
      end
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat full", {31'h0, rd[uart_pkg::rstat_full]}, 32'h1);
      for (int k = 0; k < 128; k++)
      begin
         expect_reg("dr", uart_pkg::reg_dr, {24'h0, sent[k]});
         bus_write(uart_pkg::reg_pop, 32'h0);
      end
      bus_read(uart_pkg::reg_rstat, rd);
      check("rstat", rd & 32'hff, 32'd1 << uart_pkg::rstat_empty);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
